// File: project.f
+incdir+.
qdrc_pkg.sv
qdrc_cmd_arb.sv
qdrc_wr.sv
qdrc_rd.sv
qdrc_phy.sv
qdr_controller.sv
qdr_sram_model.sv
qdrc_sva.sv
tb_qdrc.sv

// File: run.sh
#!/bin/sh
# build and run the QDR controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_qdrc -o tb_qdrc
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/tb_qdrc
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

// File: tb_qdrc.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdrc_defs.svh"

module tb_qdrc;

  import qdrc_pkg::*;

  logic clk0, reset, idelay_rdy, wr_valid, wr_ready, rd_valid, rd_ready, rd_dvld;
  logic qdr_w_n, qdr_r_n, qdr_k, qdr_dll_off_n, phy_rdy;
  qdr_dly_t    rn_dly;
  qdr_wr_req_t wr_req;
  qdr_rd_req_t rd_req;
  qdr_word_t   rd_data;
  qdr_addr_t   qdr_sa;
  qdr_beat_t   qdr_d_rise, qdr_d_fall, qdr_q_rise, qdr_q_fall;
  qdr_bw_t     qdr_bw_n_rise, qdr_bw_n_fall;

  integer    seed = 32'h4076_41f1;
  int        cyc = 0;
  int        max_inflight = 0;
  logic      wr_acc = 1'b0;
  logic      rd_acc = 1'b0;
  logic      k_last = 1'b0;
  qdr_word_t shadow [qdr_addr_t];
  qdr_word_t exp_q [$];
  int        exp_cyc_q [$];

  qdr_controller dut_i (.*);

  qdr_sram_model sram_i (.*);

  always #50 clk0 = ~clk0;

  // ==================================================
  // reference model
  // ==================================================

  // same address-wide fill as the sram model
  function automatic qdr_word_t ref_read(input qdr_addr_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return {6'h2a, a, ~a, a ^ 22'h15_5555};
  endfunction

  // enabled 9-bit lanes replace the old word
  function automatic qdr_word_t ref_merge(input qdr_word_t old, input qdr_word_t d,
                                          input qdr_be_t be);
    qdr_word_t w;
    w = old;
    for (int i = 0; i < 2*`QDRC_BW_W; i++) begin
      if (be[i]) begin
        w[9*i +: 9] = d[9*i +: 9];
      end
    end
    return w;
  endfunction

  function automatic qdr_word_t rand_word();
    return qdr_word_t'({$random(seed), $random(seed), $random(seed)});
  endfunction

  // ==================================================
  // checks
  // ==================================================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input qdr_word_t exp, input qdr_word_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  // accepted requests, sampled on pre-edge values
  always @(posedge clk0) begin
    cyc = cyc + 1;
    if (wr_valid && wr_ready) begin
      shadow[wr_req.addr] = ref_merge(ref_read(wr_req.addr), wr_req.data, wr_req.be);
    end
    if (rd_valid && rd_ready) begin
      exp_q.push_back(ref_read(rd_req.addr));
      // rd_dvld seen at the negedge rn_dly+3 edges after accept
      exp_cyc_q.push_back(cyc + int'(rn_dly) + 3);
    end
    if (exp_q.size() > max_inflight) begin
      max_inflight = exp_q.size();
    end
    wr_acc <= wr_valid & wr_ready;
    rd_acc <= rd_valid & rd_ready;
  end

  // read results, in order, one pulse per read
  always @(negedge clk0) begin
    int exp_cyc;
    if (!reset && rd_dvld === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("rd_dvld pulsed with no read outstanding");
      end
      exp_cyc = exp_cyc_q.pop_front();
      if (exp_cyc != cyc) begin
        abort_run($sformatf("ERROR t=%0t rd_dvld cycle expected %0d got %0d",
                            $time, exp_cyc, cyc));
      end
      check_word("rd_data", exp_q.pop_front(), rd_data);
    end
  end

  // sram clock flips once per clk0 while the phy is up
  always @(negedge clk0) begin
    if (phy_rdy === 1'b1) begin
      check_bit("qdr_k", ~k_last, qdr_k);
    end
    k_last = qdr_k;
  end

  // ==================================================
  // drivers, called at a falling edge
  // ==================================================

  task automatic send_write(input qdr_addr_t a, input qdr_word_t d, input qdr_be_t be);
    int n;
    n = 0;
    wr_valid = 1'b1;
    wr_req = '{addr: a, data: d, be: be};
    @(negedge clk0);
    while (!wr_acc) begin
      n++;
      if (n > 50) abort_run("write request was never accepted");
      @(negedge clk0);
    end
    wr_valid = 1'b0;
  endtask

  task automatic send_read(input qdr_addr_t a);
    int n;
    n = 0;
    rd_valid = 1'b1;
    rd_req.addr = a;
    @(negedge clk0);
    while (!rd_acc) begin
      n++;
      if (n > 50) abort_run("read request was never accepted");
      @(negedge clk0);
    end
    rd_valid = 1'b0;
  endtask

  task automatic idle_ports();
    wr_valid = 1'b0;
    rd_valid = 1'b0;
    @(negedge clk0);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n > 64) abort_run("reads still outstanding after the drain timeout");
      @(negedge clk0);
    end
  endtask

  // settle wait, readies and strobes must stay quiet
  task automatic wait_phy_up();
    int n;
    n = 0;
    while (!phy_rdy) begin
      check_bit("wr_ready", 1'b0, wr_ready);
      check_bit("rd_ready", 1'b0, rd_ready);
      check_bit("qdr_w_n", 1'b1, qdr_w_n);
      check_bit("qdr_r_n", 1'b1, qdr_r_n);
      check_bit("rd_dvld", 1'b0, rd_dvld);
      check_bit("qdr_dll_off_n", 1'b0, qdr_dll_off_n);
      @(negedge clk0);
      n++;
      if (n > `QDRC_SETTLE + 8) abort_run("phy_rdy never came up");
    end
    // first count is the release edge itself
    if (n != `QDRC_SETTLE + 1) begin
      abort_run($sformatf("ERROR t=%0t phy_rdy edges expected %0d got %0d",
                          $time, `QDRC_SETTLE, n - 1));
    end
    wr_valid = 1'b0;
    rd_valid = 1'b0;
    check_bit("qdr_dll_off_n", 1'b1, qdr_dll_off_n);
  endtask

  // ==================================================
  // test sequence
  // ==================================================

  initial begin
    int n, wi, ri;
    logic exp_wr;
    clk0 = 1'b0;
    reset = 1'b1;
    idelay_rdy = 1'b1;
    rn_dly = qdr_dly_t'(1);
    wr_valid = 1'b0;
    rd_valid = 1'b0;
    wr_req = '0;
    rd_req = '0;
    repeat (5) @(negedge clk0);
    reset = 1'b0;

    // 1: settle, requests held while phy is down
    wr_valid = 1'b1;
    rd_valid = 1'b1;
    wait_phy_up();
    @(negedge clk0);

    // 2: full words written then read back
    for (int i = 0; i < 8; i++) send_write(qdr_addr_t'(32'h100 + i), rand_word(), 8'hff);
    for (int i = 0; i < 8; i++) send_read(qdr_addr_t'(32'h100 + i));
    idle_ports();
    wait_drain();

    // 3: random lane enables over full words
    for (int i = 0; i < 8; i++) begin
      send_write(qdr_addr_t'(32'h200 + i), rand_word(), 8'hff);
      send_write(qdr_addr_t'(32'h200 + i), rand_word(), qdr_be_t'($random(seed)));
    end
    for (int i = 0; i < 8; i++) send_read(qdr_addr_t'(32'h200 + i));
    idle_ports();
    wait_drain();

    // 4: both ports busy every cycle, grants alternate
    wi = 0;
    ri = 0;
    wr_valid = 1'b1;
    rd_valid = 1'b1;
    wr_req = '{addr: qdr_addr_t'(32'h300), data: rand_word(), be: 8'hff};
    rd_req.addr = qdr_addr_t'(32'h100);
    // last grant was a read, so the write port goes first
    exp_wr = 1'b1;
    for (int k = 0; k < 16; k++) begin
      @(negedge clk0);
      check_bit("wr_ready", exp_wr, wr_acc);
      check_bit("rd_ready", ~exp_wr, rd_acc);
      if (exp_wr) begin
        wi++;
        wr_req = '{addr: qdr_addr_t'(32'h300 + wi), data: rand_word(), be: 8'hff};
      end else begin
        ri++;
        rd_req.addr = qdr_addr_t'(32'h100 + ri);
      end
      exp_wr = ~exp_wr;
    end
    idle_ports();
    wait_drain();

    // 5: back-to-back reads, several in flight
    max_inflight = 0;
    for (int i = 0; i < 8; i++) send_read(qdr_addr_t'(32'h300 + i));
    for (int i = 0; i < 8; i++) send_read(qdr_addr_t'(32'h200 + i));
    idle_ports();
    wait_drain();
    if (max_inflight < 3) abort_run("back-to-back reads never overlapped");

    // 6: idelay_rdy drop takes the phy down
    idelay_rdy = 1'b0;
    n = 0;
    while (phy_rdy) begin
      n++;
      if (n > 4) abort_run("phy_rdy stayed high after idelay_rdy dropped");
      @(negedge clk0);
    end
    // both ports asking while the phy is down
    wr_valid = 1'b1;
    rd_valid = 1'b1;
    repeat (4) begin
      check_bit("phy_rdy", 1'b0, phy_rdy);
      check_bit("wr_ready", 1'b0, wr_ready);
      check_bit("rd_ready", 1'b0, rd_ready);
      @(negedge clk0);
    end
    idelay_rdy = 1'b1;
    wait_phy_up();
    @(negedge clk0);
    // contents kept across the phy restart
    for (int i = 0; i < 8; i++) send_read(qdr_addr_t'(32'h100 + i));
    idle_ports();
    wait_drain();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: qdrc_sva.sv
`timescale 1ns/1ps
`default_nettype none

module qdrc_sva (
  input wire logic clk0,
  input wire logic reset,
  input wire logic qdr_w_n,
  input wire logic qdr_r_n,
  input wire logic wr_ready,
  input wire logic rd_ready,
  input wire logic phy_rdy,
  input wire logic rd_dvld
);

  // one owner of the address bus per cycle
  a_no_rw_overlap: assert property (@(posedge clk0) disable iff (reset)
    !(!qdr_w_n && !qdr_r_n))
    else $error("qdr_w_n and qdr_r_n low together");

  a_one_ready: assert property (@(posedge clk0) disable iff (reset)
    !(wr_ready && rd_ready))
    else $error("both readies high");

  // nothing accepted before the phy is up
  a_ready_needs_phy: assert property (@(posedge clk0) disable iff (reset)
    !phy_rdy |-> !(wr_ready || rd_ready))
    else $error("ready while phy_rdy low");

  a_dvld_in_reset: assert property (@(posedge clk0) reset |=> !rd_dvld)
    else $error("rd_dvld high during reset");

endmodule

bind qdr_controller qdrc_sva sva_i (.*);

`default_nettype wire

// File: qdr_sram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdrc_defs.svh"

module qdr_sram_model (
  input  wire logic                clk0,
  input  wire qdrc_pkg::qdr_addr_t qdr_sa,
  input  wire logic                qdr_w_n,
  input  wire logic                qdr_r_n,
  input  wire qdrc_pkg::qdr_beat_t qdr_d_rise,
  input  wire qdrc_pkg::qdr_beat_t qdr_d_fall,
  input  wire qdrc_pkg::qdr_bw_t   qdr_bw_n_rise,
  input  wire qdrc_pkg::qdr_bw_t   qdr_bw_n_fall,
  output qdrc_pkg::qdr_beat_t      qdr_q_rise,
  output qdrc_pkg::qdr_beat_t      qdr_q_fall
);

  import qdrc_pkg::*;

  // sparse array, only touched words are stored
  qdr_word_t mem [qdr_addr_t];

  // word on the read pads, low half rise and high half fall
  qdr_word_t rd_word = '0;

  // unwritten words, pattern built from every address bit
  function automatic qdr_word_t fill_word(input qdr_addr_t a);
    return {6'h2a, a, ~a, a ^ 22'h15_5555};
  endfunction

  function automatic qdr_word_t peek(input qdr_addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_word(a);
  endfunction

  assign qdr_q_rise = rd_word[`QDRC_DATA_W-1:0];
  assign qdr_q_fall = rd_word[2*`QDRC_DATA_W-1:`QDRC_DATA_W];

  // ==================================================
  // write and read ports
  // ==================================================

  // write applied in the qdr_w_n cycle, lanes active low
  // read data driven the cycle after the qdr_r_n cycle
  always @(posedge clk0) begin
    qdr_word_t w;
    if (qdr_w_n === 1'b0) begin
      w = peek(qdr_sa);
      for (int i = 0; i < `QDRC_BW_W; i++) begin
        if (!qdr_bw_n_rise[i]) begin
          w[9*i +: 9] = qdr_d_rise[9*i +: 9];
        end
        if (!qdr_bw_n_fall[i]) begin
          w[`QDRC_DATA_W + 9*i +: 9] = qdr_d_fall[9*i +: 9];
        end
      end
      mem[qdr_sa] = w;
    end
    if (qdr_r_n === 1'b0) begin
      rd_word <= peek(qdr_sa);
    end
  end

endmodule

`default_nettype wire

// File: qdr_controller.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_controller (
  input  wire logic                  clk0,
  // release once the clock is stable
  input  wire logic                  reset,
  input  wire logic                  idelay_rdy,
  input  wire qdrc_pkg::qdr_dly_t    rn_dly,
  // user write port
  input  wire logic                  wr_valid,
  input  wire qdrc_pkg::qdr_wr_req_t wr_req,
  output logic                       wr_ready,
  // user read port
  input  wire logic                  rd_valid,
  input  wire qdrc_pkg::qdr_rd_req_t rd_req,
  output logic                       rd_ready,
  output qdrc_pkg::qdr_word_t        rd_data,
  output logic                       rd_dvld,
  // sram pads
  output qdrc_pkg::qdr_addr_t        qdr_sa,
  output logic                       qdr_w_n,
  output logic                       qdr_r_n,
  output qdrc_pkg::qdr_beat_t        qdr_d_rise,
  output qdrc_pkg::qdr_beat_t        qdr_d_fall,
  output qdrc_pkg::qdr_bw_t          qdr_bw_n_rise,
  output qdrc_pkg::qdr_bw_t          qdr_bw_n_fall,
  input  wire qdrc_pkg::qdr_beat_t   qdr_q_rise,
  input  wire qdrc_pkg::qdr_beat_t   qdr_q_fall,
  output logic                       qdr_k,
  output logic                       qdr_dll_off_n,
  output logic                       phy_rdy
);

  import qdrc_pkg::*;

  logic         wr_grant;
  logic         rd_grant;
  qdr_wr_req_t  grant_wr;
  qdr_rd_req_t  grant_rd;
  qdr_pad_cmd_t wr_cmd;
  qdr_pad_cmd_t rd_cmd;
  qdr_word_t    q_word;

  // ==================================================
  // address bus arbitration
  // ==================================================

  qdrc_cmd_arb arb_i (
    .clk0     (clk0),
    .reset    (reset),
    .phy_rdy  (phy_rdy),
    .wr_valid (wr_valid),
    .wr_req   (wr_req),
    .rd_valid (rd_valid),
    .rd_req   (rd_req),
    .wr_ready (wr_ready),
    .rd_ready (rd_ready),
    .wr_grant (wr_grant),
    .rd_grant (rd_grant),
    .grant_wr (grant_wr),
    .grant_rd (grant_rd)
  );

  // write and read paths
  qdrc_wr wr_i (
    .clk0     (clk0),
    .reset    (reset),
    .wr_grant (wr_grant),
    .grant_wr (grant_wr),
    .wr_cmd   (wr_cmd)
  );

  qdrc_rd rd_i (
    .clk0     (clk0),
    .reset    (reset),
    .rd_grant (rd_grant),
    .grant_rd (grant_rd),
    .rn_dly   (rn_dly),
    .q_word   (q_word),
    .rd_cmd   (rd_cmd),
    .rd_data  (rd_data),
    .rd_dvld  (rd_dvld)
  );

  // ==================================================
  // pad side
  // ==================================================

  qdrc_phy phy_i (
    .clk0          (clk0),
    .reset         (reset),
    .idelay_rdy    (idelay_rdy),
    .cmd           ({wr_cmd, rd_cmd}),
    .qdr_q         ({qdr_q_fall, qdr_q_rise}),
    .phy_rdy       (phy_rdy),
    .q_word        (q_word),
    .qdr_sa        (qdr_sa),
    .qdr_w_n       (qdr_w_n),
    .qdr_r_n       (qdr_r_n),
    .qdr_d_rise    (qdr_d_rise),
    .qdr_d_fall    (qdr_d_fall),
    .qdr_bw_n_rise (qdr_bw_n_rise),
    .qdr_bw_n_fall (qdr_bw_n_fall),
    .qdr_k         (qdr_k),
    .qdr_dll_off_n (qdr_dll_off_n)
  );

endmodule

`default_nettype wire

// File: qdrc_phy.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdrc_defs.svh"

module qdrc_phy (
  input  wire logic                         clk0,
  input  wire logic                         reset,
  input  wire logic                         idelay_rdy,
  // [1] from the write path, [0] from the read path
  input  wire qdrc_pkg::qdr_pad_cmd_t [1:0] cmd,
  input  wire qdrc_pkg::qdr_word_t          qdr_q,
  output logic                              phy_rdy,
  output qdrc_pkg::qdr_word_t               q_word,
  output qdrc_pkg::qdr_addr_t               qdr_sa,
  output logic                              qdr_w_n,
  output logic                              qdr_r_n,
  output qdrc_pkg::qdr_beat_t               qdr_d_rise,
  output qdrc_pkg::qdr_beat_t               qdr_d_fall,
  output qdrc_pkg::qdr_bw_t                 qdr_bw_n_rise,
  output qdrc_pkg::qdr_bw_t                 qdr_bw_n_fall,
  output logic                              qdr_k,
  output logic                              qdr_dll_off_n
);

  import qdrc_pkg::*;

  localparam int CMD_RD = 0;
  localparam int CMD_WR = 1;
  localparam int CNT_W  = $clog2(`QDRC_SETTLE);
  // one cycle lost to the reset retime, one to PHY_RESET
  localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(`QDRC_SETTLE - 2);

  logic             rst_q;
  phy_state_t       state;
  logic [CNT_W-1:0] settle_cnt;
  qdr_pad_cmd_t     merged;

  // ==================================================
  // reset combine and settle
  // ==================================================

  // delay elements not ready counts as reset
  always_ff @(posedge clk0) begin
    rst_q <= reset | ~idelay_rdy;
  end

  always_ff @(posedge clk0) begin
    if (rst_q) begin
      state         <= PHY_RESET;
      settle_cnt    <= '0;
      qdr_dll_off_n <= 1'b0;
    end else begin
      case (state)
        PHY_RESET: begin
          state      <= PHY_SETTLE;
          settle_cnt <= '0;
        end
        PHY_SETTLE: begin
          if (settle_cnt == SETTLE_LAST) begin
            state         <= PHY_READY;
            // sram dll enabled together with phy_rdy
            qdr_dll_off_n <= 1'b1;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        PHY_READY: begin
          // stay until the next reset
          state <= PHY_READY;
        end
        default: state <= PHY_RESET;
      endcase
    end
  end

  assign phy_rdy = (state == PHY_READY);

  // ==================================================
  // command merge and pad registers
  // ==================================================

  // paths never drive at once, idle fields are neutral
  always_comb begin
    merged.w_n       = cmd[CMD_WR].w_n & cmd[CMD_RD].w_n;
    merged.r_n       = cmd[CMD_WR].r_n & cmd[CMD_RD].r_n;
    // address of whichever path is active
    merged.sa        = ~cmd[CMD_RD].r_n ? cmd[CMD_RD].sa : cmd[CMD_WR].sa;
    merged.d_rise    = cmd[CMD_WR].d_rise | cmd[CMD_RD].d_rise;
    merged.d_fall    = cmd[CMD_WR].d_fall | cmd[CMD_RD].d_fall;
    merged.bw_n_rise = cmd[CMD_WR].bw_n_rise & cmd[CMD_RD].bw_n_rise;
    merged.bw_n_fall = cmd[CMD_WR].bw_n_fall & cmd[CMD_RD].bw_n_fall;
  end

  // strobes and byte writes inactive in reset
  always_ff @(posedge clk0) begin
    if (rst_q) begin
      qdr_w_n       <= 1'b1;
      qdr_r_n       <= 1'b1;
      qdr_bw_n_rise <= '1;
      qdr_bw_n_fall <= '1;
      qdr_k         <= 1'b0;
    end else begin
      qdr_w_n       <= merged.w_n;
      qdr_r_n       <= merged.r_n;
      qdr_bw_n_rise <= merged.bw_n_rise;
      qdr_bw_n_fall <= merged.bw_n_fall;
      // sram clock, one toggle per clk0
      qdr_k         <= ~qdr_k;
    end
  end

  // address and data, qualified by the strobes
  always_ff @(posedge clk0) begin
    qdr_sa     <= merged.sa;
    qdr_d_rise <= merged.d_rise;
    qdr_d_fall <= merged.d_fall;
  end

  // returned data, fall half on top of rise half
  always_ff @(posedge clk0) begin
    q_word <= qdr_q;
  end

endmodule

`default_nettype wire

// File: qdrc_rd.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdrc_defs.svh"

module qdrc_rd (
  input  wire logic                  clk0,
  input  wire logic                  reset,
  input  wire logic                  rd_grant,
  input  wire qdrc_pkg::qdr_rd_req_t grant_rd,
  input  wire qdrc_pkg::qdr_dly_t    rn_dly,
  input  wire qdrc_pkg::qdr_word_t   q_word,
  output qdrc_pkg::qdr_pad_cmd_t     rd_cmd,
  output qdrc_pkg::qdr_word_t        rd_data,
  output logic                       rd_dvld
);

  import qdrc_pkg::*;

  // one stage per rn_dly value
  localparam int DLY_STAGES = 2 ** `QDRC_DLY_W;

  logic                  r_n_q;
  qdr_addr_t             sa_q;
  // tracks the phy pad register, high in the qdr_r_n cycle
  logic                  pad_vld_q;
  logic [DLY_STAGES-1:0] vld_line;

  // ==================================================
  // read command and in-flight tracking
  // ==================================================

  // one bit per read walks down the line
  // several reads can be in flight at once
  always_ff @(posedge clk0) begin
    if (reset) begin
      r_n_q     <= 1'b1;
      pad_vld_q <= 1'b0;
      vld_line  <= '0;
      rd_dvld   <= 1'b0;
    end else begin
      r_n_q     <= ~rd_grant;
      pad_vld_q <= ~r_n_q;
      vld_line  <= {vld_line[DLY_STAGES-2:0], pad_vld_q};
      // tap chosen at run time
      rd_dvld   <= vld_line[rn_dly];
    end
  end

  // read address for the phy
  always_ff @(posedge clk0) begin
    if (rd_grant) begin
      sa_q <= grant_rd.addr;
    end
  end

  // capture rn_dly+1 cycles after the qdr_r_n cycle
  always_ff @(posedge clk0) begin
    if (vld_line[rn_dly]) begin
      rd_data <= q_word;
    end
  end

  // read side of the pad command, write fields idle
  always_comb begin
    rd_cmd.w_n       = 1'b1;
    rd_cmd.r_n       = r_n_q;
    rd_cmd.sa        = sa_q;
    rd_cmd.d_rise    = '0;
    rd_cmd.d_fall    = '0;
    rd_cmd.bw_n_rise = '1;
    rd_cmd.bw_n_fall = '1;
  end

endmodule

`default_nettype wire

// File: qdrc_wr.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdrc_defs.svh"

module qdrc_wr (
  input  wire logic                  clk0,
  input  wire logic                  reset,
  input  wire logic                  wr_grant,
  input  wire qdrc_pkg::qdr_wr_req_t grant_wr,
  output qdrc_pkg::qdr_pad_cmd_t     wr_cmd
);

  import qdrc_pkg::*;

  logic      w_n_q;
  qdr_addr_t sa_q;
  qdr_word_t data_q;
  qdr_be_t   bw_n_q;

  // write strobe, idle high
  always_ff @(posedge clk0) begin
    if (reset) begin
      w_n_q <= 1'b1;
    end else begin
      w_n_q <= ~wr_grant;
    end
  end

  // granted write held for the phy
  // byte enables flipped to pad polarity here
  always_ff @(posedge clk0) begin
    if (wr_grant) begin
      sa_q   <= grant_wr.addr;
      data_q <= grant_wr.data;
      bw_n_q <= ~grant_wr.be;
    end
  end

  // ==================================================
  // write beat
  // ==================================================

  always_comb begin
    wr_cmd.w_n       = w_n_q;
    // read strobe belongs to the read path
    wr_cmd.r_n       = 1'b1;
    wr_cmd.sa        = sa_q;
    // low half on the rising edge, high half on the falling edge
    wr_cmd.d_rise    = data_q[`QDRC_DATA_W-1:0];
    wr_cmd.d_fall    = data_q[2*`QDRC_DATA_W-1:`QDRC_DATA_W];
    wr_cmd.bw_n_rise = bw_n_q[`QDRC_BW_W-1:0];
    wr_cmd.bw_n_fall = bw_n_q[2*`QDRC_BW_W-1:`QDRC_BW_W];
  end

endmodule

`default_nettype wire

// File: qdrc_cmd_arb.sv
`timescale 1ns/1ps
`default_nettype none

module qdrc_cmd_arb (
  input  wire logic                  clk0,
  input  wire logic                  reset,
  input  wire logic                  phy_rdy,
  input  wire logic                  wr_valid,
  input  wire qdrc_pkg::qdr_wr_req_t wr_req,
  input  wire logic                  rd_valid,
  input  wire qdrc_pkg::qdr_rd_req_t rd_req,
  output logic                       wr_ready,
  output logic                       rd_ready,
  output logic                       wr_grant,
  output logic                       rd_grant,
  output qdrc_pkg::qdr_wr_req_t      grant_wr,
  output qdrc_pkg::qdr_rd_req_t      grant_rd
);

  import qdrc_pkg::*;

  // who had the address bus last time
  arb_owner_t last_owner;

  logic pick_wr;
  logic pick_rd;

  // ==================================================
  // owner select
  // ==================================================

  // write wins when alone, or when the read went last
  // read wins when alone, or when the write went last
  // nothing is picked until the phy is up
  always_comb begin
    pick_wr = phy_rdy & wr_valid & (~rd_valid | (last_owner == OWNER_RD));
    pick_rd = phy_rdy & rd_valid & (~wr_valid | (last_owner == OWNER_WR));
  end

  // ready only towards the winner, so never both
  assign wr_ready = pick_wr;
  assign rd_ready = pick_rd;

  // handshake complete this cycle
  assign wr_grant = pick_wr & wr_valid;
  assign rd_grant = pick_rd & rd_valid;

  // winning request on to its path, zeros otherwise
  always_comb begin
    grant_wr = '0;
    grant_rd = '0;
    if (wr_grant) begin
      grant_wr = wr_req;
    end
    if (rd_grant) begin
      grant_rd = rd_req;
    end
  end

  // ==================================================
  // alternating priority state
  // ==================================================

  always_ff @(posedge clk0) begin
    if (reset) begin
      // first contended cycle goes to the write port
      last_owner <= OWNER_RD;
    end else if (wr_grant) begin
      last_owner <= OWNER_WR;
    end else if (rd_grant) begin
      last_owner <= OWNER_RD;
    end
  end

endmodule

`default_nettype wire

// File: qdrc_pkg.sv
`default_nettype none

`include "qdrc_defs.svh"

package qdrc_pkg;

  // widths with a meaning
  typedef logic [`QDRC_DATA_W-1:0]   qdr_beat_t;
  // low half rise beat, high half fall beat
  typedef logic [2*`QDRC_DATA_W-1:0] qdr_word_t;
  // user byte enables, active high, bit i covers bits 9i+8:9i
  typedef logic [2*`QDRC_BW_W-1:0]   qdr_be_t;
  // pad byte writes, active low
  typedef logic [`QDRC_BW_W-1:0]     qdr_bw_t;
  typedef logic [`QDRC_ADDR_W-1:0]   qdr_addr_t;
  typedef logic [`QDRC_DLY_W-1:0]    qdr_dly_t;

  // user write request
  typedef struct packed {
    qdr_addr_t addr;
    qdr_word_t data;
    qdr_be_t   be;
  } qdr_wr_req_t;

  // user read request
  typedef struct packed {
    qdr_addr_t addr;
  } qdr_rd_req_t;

  // everything the phy puts on the pads for one cycle
  typedef struct packed {
    logic      w_n;
    logic      r_n;
    qdr_addr_t sa;
    qdr_beat_t d_rise;
    qdr_beat_t d_fall;
    qdr_bw_t   bw_n_rise;
    qdr_bw_t   bw_n_fall;
  } qdr_pad_cmd_t;

  // last owner of the address bus
  typedef enum logic {OWNER_RD, OWNER_WR} arb_owner_t;

  typedef enum logic [1:0] {PHY_RESET, PHY_SETTLE, PHY_READY} phy_state_t;

endpackage

`default_nettype wire

// File: qdrc_defs.svh
`ifndef QDRC_DEFS_SVH
`define QDRC_DEFS_SVH

// ==================================================
// qdr sram geometry
// ==================================================

// one pad beat, rise or fall half of a user word
`define QDRC_DATA_W 36

// byte lanes per beat, 9 bits per lane
`define QDRC_BW_W 4

// burst address width
`define QDRC_ADDR_W 22

// ==================================================
// controller timing
// ==================================================

// read capture delay select, 2**5 delay stages
`define QDRC_DLY_W 5

// clk0 cycles from reset release to phy_rdy
`define QDRC_SETTLE 16

`endif
